// File: burst_mem.sv
// On-chip model with fixed read latency, only the low MEM_DEPTH_LOG address bits are used
`timescale 1ns/1ns
`include "memsys_consts.svh"

module burst_mem (
	input logic CLOCK_50,
	input logic rst,
	input memsys_pkg::mem_cmd_t cmd,
	input logic [`MEM_DN-1:0] wdata,
	output logic mem_ack,
	output logic mem_valid,
	output logic [`MEM_DN-1:0] rd_data
);

localparam int DN = `MEM_DN;
localparam int DW = `MEM_DEPTH_LOG;
localparam int DEPTH = 2 ** DW;
localparam int CN = $clog2(`MEM_BURST);
localparam int LN = $clog2(`MEM_LAT + 1);

typedef enum logic [1:0] {IDLE, WRITE, RD_WAIT, RD_STREAM} state_t;

state_t state;
logic [DN-1:0] mem [DEPTH];
logic [DW-1:0] base;
logic [DW-1:0] idx;
logic [CN-1:0] cnt;
logic [LN-1:0] delay;

assign idx = base + DW'(cnt);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= IDLE;
		mem_ack <= 1'b0;
		mem_valid <= 1'b0;
		cnt <= '0;
		delay <= '0;
	end else begin
		case (state)
		IDLE: if (cmd.start) begin
			mem_ack <= 1'b1;
			cnt <= '0;
			if (cmd.wr) begin
				state <= WRITE;
			end else begin
				state <= RD_WAIT;
				delay <= LN'(`MEM_LAT);
			end
		end
		// One ack per written word
		WRITE: begin
			cnt <= cnt + 1'b1;
			if (cnt == CN'(`MEM_BURST - 1)) begin
				mem_ack <= 1'b0;
				state <= IDLE;
			end
		end
		RD_WAIT: begin
			mem_ack <= 1'b0;
			delay <= delay - 1'b1;
			// Word 0 is loaded on this edge
			if (delay == LN'(1)) begin
				mem_valid <= 1'b1;
				cnt <= CN'(1);
				state <= RD_STREAM;
			end
		end
		RD_STREAM: begin
			cnt <= cnt + 1'b1;
			// Counter has wrapped after the last word
			if (cnt == '0) begin
				mem_valid <= 1'b0;
				state <= IDLE;
			end
		end
		default: state <= IDLE;
		endcase
	end
end

// Storage and read port
always_ff @(posedge CLOCK_50) begin
	if (state == IDLE && cmd.start)
		base <= cmd.addr[DW-1:0];
	if (state == WRITE)
		mem[idx] <= wdata;
	rd_data <= mem[idx];
end

// Arbiter must wait for the running burst to end
start_idle: assert property (@(posedge CLOCK_50) disable iff (rst)
	cmd.start |-> state == IDLE);

endmodule

// File: frame_fetch.sv
// One read burst in flight, 32-word FIFO; FRAME_WORDS must be a multiple of MEM_BURST
`timescale 1ns/1ns
`include "memsys_consts.svh"

module frame_fetch #(
	parameter logic [`MEM_AN-1:0] FRAME_BASE = '0,
	parameter int FRAME_WORDS = 64
) (
	input logic CLOCK_50,
	input logic rst,
	input logic fetch_en,
	output memsys_pkg::mem_req_t req,
	input logic ack,
	input logic valid,
	input logic [`MEM_DN-1:0] rd_data,
	input logic pix_rd,
	output logic [`MEM_DN-1:0] pix,
	output logic [5:0] level,
	output logic empty,
	output logic full
);

localparam int AN = `MEM_AN;
localparam int DN = `MEM_DN;
localparam int CN = $clog2(`MEM_BURST);
localparam int FD = 32;
localparam int FA = $clog2(FD);

typedef enum logic [1:0] {IDLE, REQ, WAIT} state_t;

state_t state;
logic [AN-1:0] off;
logic [CN-1:0] cnt;
logic room;
logic [DN-1:0] fifo [FD];
logic [FA-1:0] wp;
logic [FA-1:0] rp;
logic pop;

// Whole burst must fit before asking
assign room = level <= 6'(FD - `MEM_BURST);
assign pop = pix_rd && !empty;

assign req.req = state == REQ;
assign req.wr = 1'b0;
assign req.addr = FRAME_BASE + off;
assign req.data = '0;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= IDLE;
		off <= '0;
		cnt <= '0;
	end else begin
		case (state)
		IDLE: if (!fetch_en)
			off <= '0;
		else if (room)
			state <= REQ;
		REQ: if (ack) begin
			state <= WAIT;
			cnt <= '0;
			if (off == AN'(FRAME_WORDS - `MEM_BURST))
				off <= '0;
			else
				off <= off + AN'(`MEM_BURST);
		end
		WAIT: if (valid) begin
			cnt <= cnt + 1'b1;
			if (cnt == CN'(`MEM_BURST - 1))
				state <= IDLE;
		end
		default: state <= IDLE;
		endcase
	end
end

// Pixel FIFO
always_ff @(posedge CLOCK_50) begin
	if (valid)
		fifo[wp] <= rd_data;
end

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		wp <= '0;
		rp <= '0;
		level <= '0;
	end else begin
		if (valid)
			wp <= wp + 1'b1;
		if (pop)
			rp <= rp + 1'b1;
		level <= level + 6'(valid) - 6'(pop);
	end
end

assign pix = fifo[rp];
assign empty = level == '0;
assign full = level == 6'(FD);

no_push_full: assert property (@(posedge CLOCK_50) disable iff (rst)
	valid |-> !full);

endmodule

// File: mem_arbiter.sv
// Round-robin over MEM_IN slots with one burst in flight; slot 0 has first turn after reset
`timescale 1ns/1ns
`include "memsys_consts.svh"

module mem_arbiter (
	input logic CLOCK_50,
	input logic rst,
	input memsys_pkg::mem_req_t cli_req [`MEM_IN],
	output logic [`MEM_IN-1:0] cli_ack,
	output logic [`MEM_IN-1:0] cli_valid,
	output memsys_pkg::mem_cmd_t cmd,
	output logic [`MEM_DN-1:0] wdata,
	input logic mem_ack,
	input logic mem_valid
);

localparam int IN = `MEM_IN;
localparam int SN = $clog2(IN);
localparam int CN = $clog2(`MEM_BURST);

logic [IN-1:0] grant;
logic [SN-1:0] cur;
logic wr_burst;
logic [CN-1:0] beat;
logic beat_ev;
logic found;
logic [SN-1:0] pick;

// First requester after the slot served last
always_comb begin
	logic [SN-1:0] cand;
	found = 1'b0;
	pick = cur;
	for (int i = 1; i <= IN; i++) begin
		cand = SN'((int'(cur) + i) % IN);
		if (!found && cli_req[cand].req) begin
			found = 1'b1;
			pick = cand;
		end
	end
end

// Writes end on the last ack, reads on the last valid
assign beat_ev = wr_burst ? mem_ack : mem_valid;

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		grant <= '0;
		cur <= SN'(IN - 1);
		wr_burst <= 1'b0;
		beat <= '0;
		cmd <= '0;
	end else begin
		cmd.start <= 1'b0;
		if (grant == '0) begin
			if (found) begin
				grant <= IN'(1) << pick;
				cur <= pick;
				wr_burst <= cli_req[pick].wr;
				beat <= '0;
				cmd.start <= 1'b1;
				cmd.wr <= cli_req[pick].wr;
				cmd.addr <= cli_req[pick].addr;
			end
		end else if (beat_ev) begin
			beat <= beat + 1'b1;
			if (beat == CN'(`MEM_BURST - 1))
				grant <= '0;
		end
	end
end

// Strobes go to the granted slot only
assign cli_ack = mem_ack ? grant : '0;
assign cli_valid = mem_valid ? grant : '0;
assign wdata = cli_req[cur].data;

// Memory strobes arrive only while exactly one slot holds the grant
grant_onehot: assert property (@(posedge CLOCK_50) disable iff (rst)
	(mem_ack || mem_valid) |-> $onehot(grant));

// Writing client keeps its request up for the whole burst
wr_req_held: assert property (@(posedge CLOCK_50) disable iff (rst)
	(grant != '0 && wr_burst) |-> cli_req[cur].req);

endmodule

// File: mem_test.sv
// Writes the whole region first, then reads it back; start is taken only while idle
`timescale 1ns/1ns
`include "memsys_consts.svh"

module mem_test #(
	parameter logic [`MEM_AN-1:0] TEST_BASE = 24'h000800,
	parameter int TEST_WORDS = 128
) (
	input logic CLOCK_50,
	input logic rst,
	input logic start,
	output memsys_pkg::mem_req_t req,
	input logic ack,
	input logic valid,
	input logic [`MEM_DN-1:0] rd_data,
	output logic done,
	output logic fail
);

localparam int AN = `MEM_AN;
localparam int DN = `MEM_DN;
localparam int CN = $clog2(`MEM_BURST);
localparam logic [DN-1:0] PAT_KEY = DN'('h5A5A);

typedef enum logic [2:0] {IDLE, WR_REQ, WR_GAP, RD_REQ, RD_WAIT} state_t;

state_t state;
logic [AN-1:0] off;
logic [AN-1:0] off_next;
logic [AN-1:0] burst_addr;
logic [AN-1:0] word_addr;
logic [CN-1:0] beat;
logic last_beat;

// Address-derived test word
function automatic logic [DN-1:0] pattern(input logic [AN-1:0] a);
	return a[DN-1:0] ^ PAT_KEY;
endfunction

assign burst_addr = TEST_BASE + off;
assign word_addr = burst_addr + AN'(beat);
assign off_next = (off == AN'(TEST_WORDS - `MEM_BURST)) ? '0 : off + AN'(`MEM_BURST);
assign last_beat = beat == CN'(`MEM_BURST - 1);

assign req.req = state == WR_REQ || state == RD_REQ;
assign req.wr = state == WR_REQ;
assign req.addr = burst_addr;
assign req.data = pattern(word_addr);

always_ff @(posedge CLOCK_50) begin
	if (rst) begin
		state <= IDLE;
		off <= '0;
		beat <= '0;
		done <= 1'b0;
		fail <= 1'b0;
	end else begin
		case (state)
		IDLE: if (start) begin
			done <= 1'b0;
			fail <= 1'b0;
			off <= '0;
			beat <= '0;
			state <= WR_REQ;
		end
		WR_REQ: if (ack) begin
			beat <= beat + 1'b1;
			if (last_beat) begin
				beat <= '0;
				off <= off_next;
				state <= WR_GAP;
			end
		end
		// Request drops for a cycle, offset back at zero means all written
		WR_GAP: state <= (off == '0) ? RD_REQ : WR_REQ;
		RD_REQ: if (ack)
			state <= RD_WAIT;
		RD_WAIT: if (valid) begin
			if (rd_data != pattern(word_addr))
				fail <= 1'b1;
			beat <= beat + 1'b1;
			if (last_beat) begin
				beat <= '0;
				off <= off_next;
				if (off_next == '0) begin
					done <= 1'b1;
					state <= IDLE;
				end else begin
					state <= RD_REQ;
				end
			end
		end
		default: state <= IDLE;
		endcase
	end
end

// Read data only for a read this client started
valid_in_read: assert property (@(posedge CLOCK_50) disable iff (rst)
	valid |-> state == RD_WAIT);

endmodule

// File: memsys_consts.svh
// Compile-time sizes; burst length must be a power of two and memory latency at least 1
`ifndef MEMSYS_CONSTS_SVH
`define MEMSYS_CONSTS_SVH

// Bus widths
`define MEM_AN 24
`define MEM_DN 16

// Client slots
`define MEM_IN 4
`define CLI_FRAME 0
`define CLI_EXT 1
`define CLI_TEST 3

// Burst memory model
`define MEM_BURST 8
`define MEM_LAT 2

// Model size in words as log2, addresses wrap at this size
`define MEM_DEPTH_LOG 12

`endif

// File: memsys_pkg.sv
// Request and command types shared by the arbiter, memory model and clients
`include "memsys_consts.svh"

package memsys_pkg;

	// One client request, held until the final ack
	typedef struct packed {
		logic req;
		logic wr;
		logic [`MEM_AN-1:0] addr;
		// Write word, advanced by the client on each ack
		logic [`MEM_DN-1:0] data;
	} mem_req_t;

	// Arbiter to memory, start lasts one cycle per burst
	typedef struct packed {
		logic start;
		logic wr;
		logic [`MEM_AN-1:0] addr;
	} mem_cmd_t;

endpackage

// File: memsys_top.sv
// Single clock domain; slot 2 is unused and ext_req must follow the client request protocol
`timescale 1ns/1ns
`include "memsys_consts.svh"

module memsys_top (
	input logic CLOCK_50,
	input logic rst,
	input logic fetch_en,
	input logic pix_rd,
	output logic [`MEM_DN-1:0] pix,
	output logic [5:0] fifo_level,
	output logic fifo_empty,
	input logic test_start,
	output logic test_done,
	output logic test_fail,
	input memsys_pkg::mem_req_t ext_req,
	output logic ext_ack,
	output logic ext_valid,
	output logic [`MEM_DN-1:0] rd_data
);

memsys_pkg::mem_req_t cli_req [`MEM_IN];
logic [`MEM_IN-1:0] cli_ack;
logic [`MEM_IN-1:0] cli_valid;
memsys_pkg::mem_cmd_t cmd;
logic [`MEM_DN-1:0] wdata;
logic mem_ack;
logic mem_valid;

mem_arbiter i_arb (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.cli_req(cli_req),
	.cli_ack(cli_ack),
	.cli_valid(cli_valid),
	.cmd(cmd),
	.wdata(wdata),
	.mem_ack(mem_ack),
	.mem_valid(mem_valid)
);

burst_mem i_mem (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.cmd(cmd),
	.wdata(wdata),
	.mem_ack(mem_ack),
	.mem_valid(mem_valid),
	.rd_data(rd_data)
);

// Spare slot
assign cli_req[2] = '0;

// External port
assign cli_req[`CLI_EXT] = ext_req;
assign ext_ack = cli_ack[`CLI_EXT];
assign ext_valid = cli_valid[`CLI_EXT];

frame_fetch #(
	.FRAME_BASE(24'h000000),
	.FRAME_WORDS(64)
) i_frame (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.fetch_en(fetch_en),
	.req(cli_req[`CLI_FRAME]),
	.ack(cli_ack[`CLI_FRAME]),
	.valid(cli_valid[`CLI_FRAME]),
	.rd_data(rd_data),
	.pix_rd(pix_rd),
	.pix(pix),
	.level(fifo_level),
	.empty(fifo_empty),
	.full()
);

mem_test #(
	.TEST_BASE(24'h000800),
	.TEST_WORDS(128)
) i_test (
	.CLOCK_50(CLOCK_50),
	.rst(rst),
	.start(test_start),
	.req(cli_req[`CLI_TEST]),
	.ack(cli_ack[`CLI_TEST]),
	.valid(cli_valid[`CLI_TEST]),
	.rd_data(rd_data),
	.done(test_done),
	.fail(test_fail)
);

endmodule

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_memsys -f src.f -o sim_memsys

out=$(./obj_dir/sim_memsys)
echo "$out"

echo "$out" | grep -q -F '*** PASSED ***'

// File: src.f
+incdir+.
memsys_pkg.sv
burst_mem.sv
mem_arbiter.sv
frame_fetch.sv
mem_test.sv
memsys_top.sv
tb_memsys.sv

// File: tb_memsys.sv
// Needs --timing; expects the 64-word frame at address 0 and the test region at 0x800
`timescale 1ns/1ns
`include "memsys_consts.svh"

module tb_memsys;

localparam int DN = `MEM_DN;
localparam int AN = `MEM_AN;
localparam int BURST = `MEM_BURST;
localparam int DEPTH = 2 ** `MEM_DEPTH_LOG;
localparam int FRAME_WORDS = 64;
localparam int FIFO_DEPTH = 32;
localparam int SCRATCH = 'h100;
localparam int TIMEOUT = 10000;

logic CLOCK_50;
logic rst;
logic fetch_en;
logic pix_rd;
logic [DN-1:0] pix;
logic [5:0] fifo_level;
logic fifo_empty;
logic test_start;
logic test_done;
logic test_fail;
memsys_pkg::mem_req_t ext_req;
logic ext_ack;
logic ext_valid;
logic [DN-1:0] rd_data;

int seed;
int errors;
int timeouts;
int pix_count;
// Expected memory contents
logic [DN-1:0] shadow [DEPTH];
logic [DN-1:0] wbuf [BURST];
logic [DN-1:0] rbuf [BURST];
int rlen;

// Results waiting for the compare process
string name_q [$];
logic [DN-1:0] exp_q [$];
logic [DN-1:0] act_q [$];
string cmp_name;
logic [DN-1:0] cmp_exp;
logic [DN-1:0] cmp_act;

memsys_top i_memsys_top (.*);

initial begin
	CLOCK_50 = 1'b0;
	forever #5 CLOCK_50 = ~CLOCK_50;
end

function automatic logic [DN-1:0] pattern(input int a);
	return DN'(a) ^ 16'h5A5A;
endfunction

function automatic logic [DN-1:0] expected_pixel(input int k);
	return shadow[k % FRAME_WORDS];
endfunction

task automatic queue_result(input string name, input logic [DN-1:0] e, input logic [DN-1:0] a);
	name_q.push_back(name);
	exp_q.push_back(e);
	act_q.push_back(a);
endtask

always @(negedge CLOCK_50) begin
	while (act_q.size() > 0) begin
		cmp_name = name_q.pop_front();
		cmp_exp = exp_q.pop_front();
		cmp_act = act_q.pop_front();
		if (cmp_act !== cmp_exp) begin
			$display("mismatch %s expected %h actual %h", cmp_name, cmp_exp, cmp_act);
			errors++;
		end
	end
end

task automatic report_timeout(input string what);
	$display("timeout while waiting for %s", what);
	timeouts++;
endtask

// Word n is presented until its ack has passed
task automatic write_burst(input int addr);
	int i;
	int n;
	int t;
	for (i = 0; i < BURST; i++) begin
		wbuf[i] = DN'($random(seed));
		shadow[(addr + i) % DEPTH] = wbuf[i];
	end
	ext_req.req = 1'b1;
	ext_req.wr = 1'b1;
	ext_req.addr = AN'(addr);
	ext_req.data = wbuf[0];
	n = 0;
	t = 0;
	while (n < BURST && t < TIMEOUT) begin
		@(negedge CLOCK_50);
		t++;
		if (ext_ack) begin
			@(posedge CLOCK_50);
			#1;
			n++;
			if (n < BURST)
				ext_req.data = wbuf[n];
		end
	end
	if (n < BURST) begin
		report_timeout("write burst ack");
		@(posedge CLOCK_50);
		#1;
	end
	ext_req = '0;
	@(posedge CLOCK_50);
	#1;
endtask

task automatic read_burst(input int addr);
	int i;
	int t;
	logic got;
	ext_req.req = 1'b1;
	ext_req.wr = 1'b0;
	ext_req.addr = AN'(addr);
	ext_req.data = '0;
	got = 1'b0;
	t = 0;
	while (!got && t < TIMEOUT) begin
		@(negedge CLOCK_50);
		t++;
		got = ext_ack;
	end
	if (!got)
		report_timeout("read burst ack");
	@(posedge CLOCK_50);
	#1;
	ext_req = '0;
	rlen = 0;
	t = 0;
	while (rlen < BURST && t < TIMEOUT) begin
		@(negedge CLOCK_50);
		t++;
		if (ext_valid) begin
			rbuf[rlen] = rd_data;
			rlen++;
		end
	end
	if (rlen < BURST)
		report_timeout("read data");
	// Any later valid is an extra word
	for (i = 0; i < 4; i++) begin
		@(negedge CLOCK_50);
		if (ext_valid)
			rlen++;
	end
	@(posedge CLOCK_50);
	#1;
endtask

task automatic read_and_compare(input string name, input int addr);
	int i;
	read_burst(addr);
	queue_result({name, " length"}, DN'(BURST), DN'(rlen));
	for (i = 0; i < BURST; i++)
		queue_result(name, shadow[(addr + i) % DEPTH], rbuf[i]);
endtask

// Idle timeout restarts with every popped pixel
task automatic pop_pixels(input int n);
	int k;
	int t;
	k = 0;
	t = 0;
	while (k < n && t < TIMEOUT) begin
		@(posedge CLOCK_50);
		#1;
		pix_rd = 1'b0;
		if (!fifo_empty) begin
			pix_rd = 1'b1;
			queue_result("pixel order", expected_pixel(pix_count), pix);
			queue_result("fifo_level range", 1'b1,
				DN'(fifo_level != 0 && fifo_level <= FIFO_DEPTH));
			pix_count++;
			k++;
			t = 0;
		end else begin
			t++;
		end
	end
	if (k < n)
		report_timeout("pixels");
	@(posedge CLOCK_50);
	#1;
	pix_rd = 1'b0;
endtask

task automatic pulse_test_start;
	test_start = 1'b1;
	@(posedge CLOCK_50);
	#1;
	test_start = 1'b0;
endtask

task automatic wait_test_done;
	int t;
	t = 0;
	while (test_done !== 1'b1 && t < TIMEOUT) begin
		@(posedge CLOCK_50);
		#1;
		t++;
	end
	if (test_done !== 1'b1)
		report_timeout("test_done");
endtask

task automatic ext_traffic;
	int b;
	for (b = 0; b < 8; b++)
		write_burst(SCRATCH + b * BURST);
	for (b = 0; b < 8; b++)
		read_and_compare("contention readback", SCRATCH + b * BURST);
endtask

initial begin
	int a;
	int b;
	int t;
	seed = 2;
	errors = 0;
	timeouts = 0;
	pix_count = 0;
	rst = 1'b1;
	fetch_en = 1'b0;
	pix_rd = 1'b0;
	test_start = 1'b0;
	ext_req = '0;
	repeat (2) @(posedge CLOCK_50);
	#1;
	rst = 1'b0;

	queue_result("reset ext_ack", 1'b0, ext_ack);
	queue_result("reset ext_valid", 1'b0, ext_valid);
	queue_result("reset test_done", 1'b0, test_done);
	queue_result("reset test_fail", 1'b0, test_fail);
	queue_result("reset fifo_empty", 1'b1, fifo_empty);
	queue_result("reset fifo_level", '0, DN'(fifo_level));

	// Frame contents through the external port
	for (b = 0; b < FRAME_WORDS / BURST; b++)
		write_burst(b * BURST);
	for (b = 0; b < FRAME_WORDS / BURST; b++)
		read_and_compare("ext readback", b * BURST);

	// Fetch stays on from here so the pixel order carries on
	fetch_en = 1'b1;
	pop_pixels(192);

	for (a = 'h800; a < 'h880; a++)
		shadow[a] = pattern(a);
	pulse_test_start();
	wait_test_done();
	queue_result("test_fail", 1'b0, test_fail);
	for (b = 0; b < 16; b++)
		read_and_compare("test region", 'h800 + b * BURST);

	pulse_test_start();
	fork
		pop_pixels(192);
		ext_traffic();
		begin
			wait_test_done();
			queue_result("test_fail under contention", 1'b0, test_fail);
		end
	join

	t = 0;
	while (act_q.size() > 0 && t < 100) begin
		@(negedge CLOCK_50);
		t++;
	end
	#1;
	$display("errors %0d timeouts %0d", errors, timeouts);
	if (errors == 0 && timeouts == 0)
		$display("*** PASSED ***");
	else
		$display("*** FAILED ***");
	$finish;
end

endmodule
